// File: project.f
verilog/gamePkg.sv
verilog/frameTimer.sv
verilog/randomGen.sv
verilog/speedControl.sv
verilog/treeLogic.sv
verilog/deployScheduler.sv
verilog/collisionDetect.sv
verilog/skiSlopeTop.sv
verif/skiSlopeTb.sv

// File: verif/skiSlopeTb.sv
`timescale 1ns/1ps

module skiSlopeTb;
	import gamePkg::*;

	localparam int NUM_TREES = 3;
	localparam int FRAME_CYCLES = 16;
	localparam int SPEEDUP_FRAMES = 8;
	localparam int DEPLOY_FRAMES = 4;
	localparam int CLK_PERIOD = 100; // ns
	localparam int START_GAP = 160; // rows between tree start positions
	localparam int MAX_COLUMN = 637; // widest reload column allowed
	localparam int PARK_X = 900; // right of every tree box, no overlap possible
	localparam int MOTION_FRAMES = 80; // long enough to saturate speed
	localparam int WRAP_LIMIT = 400;
	localparam int DEPLOY_LIMIT = 400;
	localparam int COLLISION_LIMIT = 2000;
	localparam int COLLISION_PASSES = 3; // scored passes wanted before stopping
	localparam int TOTAL_FRAMES = MOTION_FRAMES + WRAP_LIMIT + DEPLOY_LIMIT + COLLISION_LIMIT;
	localparam int WATCHDOG_NS = (TOTAL_FRAMES + 8) * FRAME_CYCLES * CLK_PERIOD * 2;

	logic clk;
	logic resetN;
	coordT playerX;
	coordT [NUM_TREES-1:0] treeX;
	coordT [NUM_TREES-1:0] treeY;
	logic [NUM_TREES-1:0] treeActive;
	logic [NUM_TREES-1:0] treeJump;
	speedT speed;
	logic hit;
	hitCountT hitCount;

	// reference model state
	int yFix[NUM_TREES]; // predicted row, 1/64 pixel
	coordT lastX[NUM_TREES]; // coordinates seen after the latest frame
	coordT lastY[NUM_TREES];
	int deployFrame[NUM_TREES];
	int firstJump[NUM_TREES]; // first DUT jump at or after the deploy
	int actFrame[NUM_TREES]; // frame in which the DUT raised isActive
	logic [NUM_TREES-1:0] activeModel;
	logic [NUM_TREES-1:0] activeSeen;
	logic [NUM_TREES-1:0] sentModel; // trees the scheduler has already released
	logic [NUM_TREES-1:0] countedModel; // passes already scored
	logic [NUM_TREES-1:0] lastJump;
	int speedModel;
	int speedFrames; // frames since last speed change
	int hitModel;
	int passesCounted;
	int frameNo;
	coordT drivenX; // skier column seen by the next frame check
	logic stalled = 1'b0;
	int errors = 0;
	int checks = 0;
	int testsRun = 0;
	logic [31:0] lfsrState = 32'h059d_4081;

	skiSlopeTop #(
		.NUM_TREES(NUM_TREES),
		.FRAME_CYCLES(FRAME_CYCLES),
		.SPEEDUP_FRAMES(SPEEDUP_FRAMES),
		.DEPLOY_FRAMES(DEPLOY_FRAMES)
	) DUT (
		.clk(clk),
		.resetN(resetN),
		.playerX(playerX),
		.treeX(treeX),
		.treeY(treeY),
		.treeActive(treeActive),
		.treeJump(treeJump),
		.speed(speed),
		.hit(hit),
		.hitCount(hitCount)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// x^32 + x^22 + x^2 + x + 1, one step per bit returned
	function automatic int randomBits(input int n);
		int value;
		logic fb;
		value = 0;
		for (int k = 0; k < n; k++) begin
			fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], fb};
			value = (value << 1) | fb;
		end
		return value;
	endfunction

	// half-open boxes, a shared edge is no collision
	function automatic logic boxesOverlap(input int tx, input int ty, input int px);
		logic colHit;
		logic rowHit;
		colHit = (tx < px + PLAYER_SIZE) && (px < tx + TREE_SIZE);
		rowHit = (ty < PLAYER_Y + PLAYER_SIZE) && (PLAYER_Y < ty + TREE_SIZE);
		return colHit && rowHit;
	endfunction

	task automatic compareValues(input int actual, input int expected, input string what);
		checks++;
		if (actual != expected) begin
			errors++;
			$display("FAIL %0t ns: %s (got %0d, expected %0d)", $time, what, actual, expected);
		end
	endtask

	task automatic reportTest(input string name, input int frames, input int startErrors);
		testsRun++;
		$display("%s: %0d frames, %0d errors", name, frames, errors - startErrors);
	endtask

	task automatic drivePlayer(input int x);
		@(posedge clk);
		playerX <= coordT'(x);
		drivenX = coordT'(x); // stays put until the next frame pulse
	endtask

	task automatic applyReset();
		resetN <= 1'b0;
		repeat (3) @(posedge clk);
		resetN <= 1'b1;
		for (int i = 0; i < NUM_TREES; i++) begin
			yFix[i] = (JUMP_Y - START_GAP * i) * (1 << FIXED_POINT_SHIFT); // -64 - 160*i rows
			lastY[i] = coordT'(JUMP_Y - START_GAP * i);
			deployFrame[i] = -1;
			firstJump[i] = -1;
			actFrame[i] = -1;
		end
		activeModel = '0;
		activeSeen = '0;
		sentModel = '0;
		countedModel = '0;
		lastJump = '0;
		speedModel = 0;
		speedFrames = 0;
		hitModel = 0;
		passesCounted = 0;
		frameNo = 0;
	endtask

	// waits for one frame update, checks it, then checks the cycle after it
	task automatic runFrame();
		int waited;
		int stepSpeed;
		int newCount;
		int expectPeriod;
		logic picked;
		logic [NUM_TREES-1:0] newHit;
		logic [NUM_TREES-1:0] wrapped;
		logic [NUM_TREES-1:0] nextMask;
		coordT cx;
		coordT cy;
		expectPeriod = (frameNo == 0) ? FRAME_CYCLES + 1 : FRAME_CYCLES - 1;
		waited = 0;
		// tree 0 moves at least a pixel or wraps on every frame
		do begin
			@(negedge clk);
			waited++;
		end while (treeY[0] == lastY[0] && waited < 2 * FRAME_CYCLES + 2);
		if (treeY[0] == lastY[0]) begin
			$display("no tree moved within %0d cycles after frame %0d", waited, frameNo);
			errors++;
			stalled = 1'b1;
			return;
		end
		frameNo++;
		compareValues(waited, expectPeriod, "cycles between frame updates");
		stepSpeed = speedModel; // speed held during the pulse
		newCount = 0;
		for (int i = 0; i < NUM_TREES; i++) begin
			// collision check ran on the coordinates from before this update
			newHit[i] = activeModel[i] && !countedModel[i]
				&& boxesOverlap(lastX[i], lastY[i], drivenX);
			newCount += newHit[i];
			wrapped[i] = (yFix[i] >>> FIXED_POINT_SHIFT) > SCREEN_HEIGHT - 1;
			if (wrapped[i])
				yFix[i] = JUMP_Y * (1 << FIXED_POINT_SHIFT);
			else
				yFix[i] += BASE_STEP + SPEED_GAIN * stepSpeed;
			cx = treeX[i];
			cy = treeY[i];
			compareValues(cy, yFix[i] >>> FIXED_POINT_SHIFT, $sformatf("tree %0d row", i));
			compareValues(treeJump[i], wrapped[i], $sformatf("tree %0d jump", i));
			if (wrapped[i])
				compareValues(cx >= 0 && cx <= MAX_COLUMN, 1,
					$sformatf("tree %0d new column %0d in range", i, cx));
			else
				compareValues(cx, lastX[i], $sformatf("tree %0d column held", i));
			countedModel[i] = wrapped[i] ? 1'b0 : (countedModel[i] | newHit[i]); // new pass re-arms
			lastX[i] = cx;
			lastY[i] = cy;
		end
		speedFrames++;
		if (speedFrames == SPEEDUP_FRAMES) begin
			speedFrames = 0;
			if (speedModel < MAX_SPEED)
				speedModel++;
		end
		compareValues(speed, speedModel, "speed after frame");
		compareValues(hit, newCount > 0, "hit pulse");
		hitModel = (hitModel + newCount > 255) ? 255 : hitModel + newCount;
		passesCounted += newCount;
		compareValues(hitCount, hitModel, "hit count");
		// scheduler picks from the activity before this frame's jumps
		picked = 1'b0;
		if (frameNo % DEPLOY_FRAMES == 0) begin
			for (int i = 0; i < NUM_TREES; i++) begin
				if (!picked && !activeModel[i] && !sentModel[i]) begin
					sentModel[i] = 1'b1;
					deployFrame[i] = frameNo;
					picked = 1'b1;
				end
			end
		end
		for (int i = 0; i < NUM_TREES; i++) begin
			if (treeJump[i] && deployFrame[i] >= 0 && firstJump[i] < 0)
				firstJump[i] = frameNo; // a jump in the deploy frame still counts
			if (wrapped[i] && sentModel[i])
				activeModel[i] = 1'b1; // deploy in the same frame still counts
		end
		@(negedge clk);
		compareValues(treeJump, 0, "jump lasts one cycle");
		compareValues(hit, 0, "hit lasts one cycle");
		if (newCount > 0) begin
			speedModel = 0; // crash restarts the speed ramp
			speedFrames = 0;
		end
		compareValues(speed, speedModel, "speed in cycle after frame");
		compareValues(treeActive, activeModel, "active mask");
		compareValues((activeSeen & ~treeActive) == '0, 1, "active tree dropped out");
		nextMask = treeActive + 1'b1;
		compareValues((treeActive & nextMask) == '0, 1, "trees active in index order");
		for (int i = 0; i < NUM_TREES; i++)
			if (treeActive[i] && !activeSeen[i])
				actFrame[i] = frameNo;
		activeSeen = treeActive;
		lastJump = wrapped;
	endtask

	task automatic resetStateTest();
		int startErrors;
		coordT cx;
		coordT cy;
		startErrors = errors;
		@(negedge clk);
		compareValues(treeActive, 0, "active mask after reset");
		compareValues(treeJump, 0, "jump mask after reset");
		compareValues(hit, 0, "hit after reset");
		compareValues(speed, 0, "speed after reset");
		compareValues(hitCount, 0, "hit count after reset");
		for (int i = 0; i < NUM_TREES; i++) begin
			cx = treeX[i];
			cy = treeY[i];
			compareValues(cy, JUMP_Y - START_GAP * i, $sformatf("tree %0d start row", i));
			compareValues(cx >= 0 && cx <= MAX_COLUMN, 1, $sformatf("tree %0d start column", i));
			lastX[i] = cx;
		end
		reportTest("reset state", 0, startErrors);
	endtask

	task automatic motionTest();
		int startErrors;
		int frames;
		startErrors = errors;
		frames = 0;
		drivePlayer(PARK_X);
		while (frames < MOTION_FRAMES && !stalled) begin
			runFrame();
			frames++;
		end
		compareValues(speed, MAX_SPEED, "speed saturated after ramp");
		reportTest("motion and speed", frames, startErrors);
	endtask

	task automatic wrapTest();
		int startErrors;
		int frames;
		int wraps;
		startErrors = errors;
		frames = 0;
		wraps = 0;
		while (wraps < 2 && frames < WRAP_LIMIT && !stalled) begin
			runFrame();
			frames++;
			wraps += lastJump[0];
		end
		compareValues(wraps, 2, "tree 0 wraps seen");
		reportTest("wrap-around", frames, startErrors);
	endtask

	task automatic deployTest();
		int startErrors;
		int frames;
		startErrors = errors;
		frames = 0;
		while (treeActive != '1 && frames < DEPLOY_LIMIT && !stalled) begin
			runFrame();
			frames++;
		end
		compareValues(treeActive, (1 << NUM_TREES) - 1, "all trees in play");
		for (int i = 0; i < NUM_TREES; i++) begin
			compareValues(actFrame[i], firstJump[i],
				$sformatf("tree %0d activation on first jump after deploy", i));
			compareValues(actFrame[i] >= deployFrame[i], 1, $sformatf("tree %0d woke early", i));
			if (i > 0)
				compareValues(actFrame[i] > actFrame[i-1], 1, $sformatf("tree %0d order", i));
		end
		reportTest("deployment", frames, startErrors);
	endtask

	task automatic collisionTest();
		int startErrors;
		int frames;
		int startPasses;
		int target;
		int offset;
		logic needTarget;
		startErrors = errors;
		startPasses = passesCounted;
		frames = 0;
		target = 0;
		offset = 0;
		needTarget = 1'b1;
		while (passesCounted - startPasses < COLLISION_PASSES && frames < COLLISION_LIMIT
				&& !stalled) begin
			if (needTarget) begin
				target = randomBits(2) % NUM_TREES;
				if (!activeSeen[target])
					target = 0;
				offset = randomBits(7) - 40; // -40..87, a few passes miss the box
				needTarget = 1'b0;
			end
			drivePlayer(lastX[target] + offset); // follow the target column
			runFrame();
			frames++;
			if (lastJump[target])
				needTarget = 1'b1; // new column, new aim
		end
		compareValues(passesCounted - startPasses > 0, 1, "no tree pass scored a hit");
		reportTest("collision", frames, startErrors);
	endtask

	initial begin
		resetN <= 1'b0;
		playerX <= coordT'(PARK_X);
		drivenX = coordT'(PARK_X);
		applyReset();
		resetStateTest();
		motionTest();
		wrapTest();
		deployTest();
		collisionTest();
		$display("%0d tests, %0d checks, %0d errors", testsRun, checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	// bound on all frame limits together, doubled
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired at %0t ns, a test never finished", $time);
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: verilog/collisionDetect.sv
`timescale 1ns/1ps

module collisionDetect #(
	parameter int NUM_TREES = 3
) (
	input logic clk,
	input logic resetN,
	input logic startOfFrame,
	input gamePkg::coordT playerX,
	input gamePkg::coordT [NUM_TREES-1:0] treeX,
	input gamePkg::coordT [NUM_TREES-1:0] treeY,
	input logic [NUM_TREES-1:0] treeActive,
	input logic [NUM_TREES-1:0] treeJump,
	output logic hit,
	output gamePkg::hitCountT hitCount
);
	import gamePkg::*;

	localparam int NEW_W = $clog2(NUM_TREES + 1); // fits NUM_TREES simultaneous hits
	localparam int HC_W = $bits(hitCountT);

	logic [NUM_TREES-1:0] overlap; // box intersection per tree
	logic [NUM_TREES-1:0] counted; // already scored on this pass
	logic [NUM_TREES-1:0] newHit;
	logic [NEW_W-1:0] newCount;
	logic [HC_W:0] sum; // extra bit shows overflow

	always_comb begin : boxTest
		int px;
		int tx;
		int ty;
		px = int'(playerX);
		newCount = '0;
		for (int i = 0; i < NUM_TREES; i++) begin
			tx = int'(coordT'(treeX[i])); // sign-extend, trees start above row 0
			ty = int'(coordT'(treeY[i]));
			// half-open intervals, touching edges do not collide
			overlap[i] = (tx < px + PLAYER_SIZE) && (px < tx + TREE_SIZE)
				&& (ty < PLAYER_Y + PLAYER_SIZE) && (PLAYER_Y < ty + TREE_SIZE);
			newHit[i] = treeActive[i] && overlap[i] && !counted[i];
			newCount = newCount + NEW_W'(newHit[i]);
		end
		sum = {1'b0, hitCount} + newCount;
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			counted <= '0;
			hit <= 1'b0;
			hitCount <= '0;
		end else begin
			hit <= 1'b0;
			if (startOfFrame) begin
				hit <= |newHit;
				if (sum[HC_W])
					hitCount <= '1; // stick at 255
				else
					hitCount <= sum[HC_W-1:0];
			end
			// a wrap starts a new pass, so the tree may score again
			counted <= (counted | (startOfFrame ? newHit : '0)) & ~treeJump;
		end
	end

endmodule

// File: verilog/deployScheduler.sv
`timescale 1ns/1ps

module deployScheduler #(
	parameter int NUM_TREES = 3,
	parameter int DEPLOY_FRAMES = 4
) (
	input logic clk,
	input logic resetN,
	input logic startOfFrame,
	input logic [NUM_TREES-1:0] treeActive,
	output logic [NUM_TREES-1:0] deploy
);

	localparam int CNT_W = (DEPLOY_FRAMES > 1) ? $clog2(DEPLOY_FRAMES) : 1;

	logic [CNT_W-1:0] frameCnt;
	logic [NUM_TREES-1:0] sentMask; // trees already given a deploy
	logic [NUM_TREES-1:0] candidates; // idle and not yet asked
	logic [NUM_TREES-1:0] lowest; // lowest set bit of candidates
	logic periodEnd;

	always_comb begin
		candidates = ~treeActive & ~sentMask;
		lowest = candidates & (~candidates + 1'b1); // two's complement isolates lowest bit
	end

	assign periodEnd = startOfFrame && (frameCnt == CNT_W'(DEPLOY_FRAMES - 1));

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			frameCnt <= '0;
			sentMask <= '0;
			deploy <= '0;
		end else begin
			deploy <= '0; // single-cycle pulse
			if (periodEnd) begin
				frameCnt <= '0;
				deploy <= lowest; // all zero once every tree has been sent
				sentMask <= sentMask | lowest;
			end else if (startOfFrame) begin
				frameCnt <= frameCnt + 1'b1;
			end
		end
	end

	// trees are released one at a time, in index order
	deployOneHotA: assert property (@(posedge clk) disable iff (!resetN) $onehot0(deploy))
		else $error("deploy mask %b not one-hot", deploy);

endmodule

// File: verilog/frameTimer.sv
`timescale 1ns/1ps

module frameTimer #(
	parameter int FRAME_CYCLES = 16
) (
	input logic clk,
	input logic resetN,
	output logic startOfFrame
);

	// one bit minimum so a single-cycle frame still builds
	localparam int CNT_W = (FRAME_CYCLES > 1) ? $clog2(FRAME_CYCLES) : 1;

	logic [CNT_W-1:0] cycleCnt; // cycles left until the next frame

	// counter starts at FRAME_CYCLES-1 so the first pulse lands
	// FRAME_CYCLES edges after reset goes away
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			cycleCnt <= CNT_W'(FRAME_CYCLES - 1);
			startOfFrame <= 1'b0;
		end else begin
			if (cycleCnt == '0) begin
				cycleCnt <= CNT_W'(FRAME_CYCLES - 1); // reload for the next frame
				startOfFrame <= 1'b1;
			end else begin
				cycleCnt <= cycleCnt - 1'b1;
				startOfFrame <= 1'b0; // pulse lasts a single clock
			end
		end
	end

endmodule

// File: verilog/gamePkg.sv
package gamePkg;

	// visible area in pixels
	localparam int SCREEN_WIDTH = 640;
	localparam int SCREEN_HEIGHT = 480;

	localparam int FIXED_POINT_SHIFT = 6; // positions kept in 1/64 pixel

	// object boxes, all square
	localparam int TREE_SIZE = 64;
	localparam int PLAYER_SIZE = 32;
	localparam int PLAYER_Y = 400; // skier never moves vertically

	localparam int JUMP_Y = -64; // restart row, one tree height above the top edge

	// per-frame step in fixed point: BASE_STEP + SPEED_GAIN * speed
	localparam int BASE_STEP = 64; // one pixel per frame at speed 0
	localparam int SPEED_GAIN = 32;
	localparam int MAX_SPEED = 7;

	// signed so trees can sit above row 0 before they scroll in
	typedef logic signed [10:0] coordT;

	typedef logic [2:0] speedT; // speed level 0..7

	typedef logic [7:0] randT; // lfsr output byte

	typedef logic [7:0] hitCountT; // saturates at 255

endpackage

// File: verilog/randomGen.sv
`timescale 1ns/1ps

module randomGen (
	input logic clk,
	input logic resetN,
	output gamePkg::randT random
);
	import gamePkg::*;

	localparam randT SEED = 8'hA5; // any non-zero start value
	localparam randT TAPS = 8'hB8; // x^8 + x^6 + x^5 + x^4 + 1, right-shift form

	// galois form, one xor stage per tap, steps every clock
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			random <= SEED;
		end else begin
			random <= (random >> 1) ^ (random[0] ? TAPS : randT'(0)); // feedback from lsb
		end
	end

	// all-zero is the one lock-up state of the lfsr
	neverZeroA: assert property (@(posedge clk) disable iff (!resetN) random != '0)
		else $error("lfsr reached the all-zero state");

endmodule

// File: verilog/skiSlopeTop.sv
`timescale 1ns/1ps

module skiSlopeTop #(
	parameter int NUM_TREES = 3,
	parameter int FRAME_CYCLES = 16,
	parameter int SPEEDUP_FRAMES = 8,
	parameter int DEPLOY_FRAMES = 4
) (
	input logic clk,
	input logic resetN,
	input gamePkg::coordT playerX,
	output gamePkg::coordT [NUM_TREES-1:0] treeX,
	output gamePkg::coordT [NUM_TREES-1:0] treeY,
	output logic [NUM_TREES-1:0] treeActive,
	output logic [NUM_TREES-1:0] treeJump,
	output gamePkg::speedT speed,
	output logic hit,
	output gamePkg::hitCountT hitCount
);
	import gamePkg::*;

	localparam int ROW_STAGGER = 160; // vertical gap between start rows

	logic startOfFrame;
	randT random; // shared by all trees
	logic [NUM_TREES-1:0] deploy;

	frameTimer #(
		.FRAME_CYCLES(FRAME_CYCLES)
	) frameTimerInst (
		.clk(clk),
		.resetN(resetN),
		.startOfFrame(startOfFrame)
	);

	randomGen randomGenInst (
		.clk(clk),
		.resetN(resetN),
		.random(random)
	);

	speedControl #(
		.SPEEDUP_FRAMES(SPEEDUP_FRAMES)
	) speedControlInst (
		.clk(clk),
		.resetN(resetN),
		.startOfFrame(startOfFrame),
		.hit(hit), // crash resets speed
		.speed(speed)
	);

	// tree i starts ROW_STAGGER*i rows higher so the trees never arrive together
	for (genvar i = 0; i < NUM_TREES; i++) begin : treeGen
		treeLogic #(
			.INITIAL_Y(JUMP_Y - ROW_STAGGER * i)
		) treeInst (
			.clk(clk),
			.resetN(resetN),
			.startOfFrame(startOfFrame),
			.deploy(deploy[i]),
			.random(random),
			.speed(speed),
			.coordX(treeX[i]),
			.coordY(treeY[i]),
			.isActive(treeActive[i]),
			.jump(treeJump[i])
		);
	end

	deployScheduler #(
		.NUM_TREES(NUM_TREES),
		.DEPLOY_FRAMES(DEPLOY_FRAMES)
	) deploySchedulerInst (
		.clk(clk),
		.resetN(resetN),
		.startOfFrame(startOfFrame),
		.treeActive(treeActive),
		.deploy(deploy)
	);

	collisionDetect #(
		.NUM_TREES(NUM_TREES)
	) collisionDetectInst (
		.clk(clk),
		.resetN(resetN),
		.startOfFrame(startOfFrame),
		.playerX(playerX),
		.treeX(treeX),
		.treeY(treeY),
		.treeActive(treeActive),
		.treeJump(treeJump), // re-arms each tree's hit mask
		.hit(hit),
		.hitCount(hitCount)
	);

endmodule

// File: verilog/speedControl.sv
`timescale 1ns/1ps

module speedControl #(
	parameter int SPEEDUP_FRAMES = 8
) (
	input logic clk,
	input logic resetN,
	input logic startOfFrame,
	input logic hit,
	output gamePkg::speedT speed
);
	import gamePkg::*;

	localparam int CNT_W = (SPEEDUP_FRAMES > 1) ? $clog2(SPEEDUP_FRAMES) : 1;

	logic [CNT_W-1:0] frameCnt; // frames since the last speed step
	logic stepDue;

	assign stepDue = (frameCnt == CNT_W'(SPEEDUP_FRAMES - 1));

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			frameCnt <= '0;
			speed <= '0;
		end else begin
			if (hit) begin
				// a crash throws the skier back to the slowest level
				// and restarts the wait for the next speed-up
				speed <= '0;
				frameCnt <= '0;
			end else if (startOfFrame) begin
				if (stepDue) begin
					frameCnt <= '0;
					if (speed < MAX_SPEED)
						speed <= speed + 1'b1; // holds once at the top
				end else begin
					frameCnt <= frameCnt + 1'b1;
				end
			end
		end
	end

	// top level must hold until a crash, a 3-bit level would otherwise wrap to 0
	speedRangeA: assert property (@(posedge clk) disable iff (!resetN)
		speed == speedT'(MAX_SPEED) && !hit |=> speed == speedT'(MAX_SPEED))
		else $error("speed level %0d left maximum without a hit", speed);

endmodule

// File: verilog/treeLogic.sv
`timescale 1ns/1ps

module treeLogic #(
	parameter int INITIAL_Y = -64
) (
	input logic clk,
	input logic resetN,
	input logic startOfFrame,
	input logic deploy,
	input gamePkg::randT random,
	input gamePkg::speedT speed,
	output gamePkg::coordT coordX,
	output gamePkg::coordT coordY,
	output logic isActive,
	output logic jump
);
	import gamePkg::*;

	// pixel coordinate width plus fraction bits
	localparam int FP_W = $bits(coordT) + FIXED_POINT_SHIFT;

	typedef logic signed [FP_W-1:0] fixedT;

	fixedT posX; // top-left corner, 1/64 pixel
	fixedT posY;
	fixedT step; // downward move per frame
	fixedT newX; // reload column in fixed point
	logic [9:0] column; // reload column in pixels
	logic pending; // deploy seen, waiting for the next wrap
	logic wrap; // tree has left the bottom of the screen

	always_comb begin
		step = fixedT'(BASE_STEP + SPEED_GAIN * int'(speed)); // faster levels add SPEED_GAIN each
		// 2r + r/4 + r/8 spreads 0..255 over most of the 640 columns
		column = {random, 1'b0} + random[7:2] + random[7:3];
		newX = fixedT'({column, {FIXED_POINT_SHIFT{1'b0}}});
	end

	assign wrap = coordY > coordT'(SCREEN_HEIGHT - 1); // top row already below the last line

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			posX <= newX; // random still holds its seed here
			posY <= fixedT'(INITIAL_Y * (1 << FIXED_POINT_SHIFT));
			isActive <= 1'b0;
			jump <= 1'b0;
			pending <= 1'b0;
		end else begin
			jump <= 1'b0;
			if (startOfFrame) begin
				if (wrap) begin
					posY <= fixedT'(JUMP_Y * (1 << FIXED_POINT_SHIFT)); // back above the top edge
					posX <= newX; // fresh column each pass
					jump <= 1'b1;
				end else begin
					posY <= posY + step;
				end
			end

			// deploy in the same cycle as jump counts as before it
			if (jump && (pending || deploy)) begin
				isActive <= 1'b1; // enters play only from above the screen
				pending <= 1'b0;
			end else if (deploy && !isActive) begin
				pending <= 1'b1;
			end
		end
	end

	// floor to whole pixels, arithmetic shift keeps negative rows correct
	assign coordX = coordT'(posX >>> FIXED_POINT_SHIFT);
	assign coordY = coordT'(posY >>> FIXED_POINT_SHIFT);

	// scheduler and collision mask both rely on a tree staying in play
	activeHoldA: assert property (@(posedge clk) disable iff (!resetN) isActive |=> isActive)
		else $error("tree left play");

	// a wrap puts Y at JUMP_Y, so the next frame can never wrap again
	jumpPulseA: assert property (@(posedge clk) disable iff (!resetN) jump |=> !jump)
		else $error("jump held for two cycles");

endmodule
